// ==== bench/mem_subsystem_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_props (
    input wire logic CLK,
    input wire logic rst,
    input wire logic req,
    input wire logic ack,
    input wire logic rsp_valid
);

    int unsigned ack_count;
    int unsigned rsp_count;
    logic        ack_d;

    // acknowledged requests and returned responses.
    always_ff @(posedge CLK) begin
        if (rst) begin
            ack_count <= 0;
            rsp_count <= 0;
            ack_d     <= 1'b0;
        end else begin
            ack_d <= ack;
            if (ack && !ack_d)
                ack_count <= ack_count + 1;
            if (rsp_valid)
                rsp_count <= rsp_count + 1;
        end
    end

    // ========================================================================
    // four-phase port
    // ========================================================================

    a_ack_rise: assert property (@(posedge CLK) disable iff (rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose without req high");

    a_ack_fall: assert property (@(posedge CLK) disable iff (rst)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req still high");

    // ========================================================================
    // responses
    // ========================================================================

    a_rsp_pulse: assert property (@(posedge CLK) disable iff (rst)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid high for two cycles");

    a_rsp_count: assert property (@(posedge CLK) disable iff (rst)
        rsp_valid |-> (rsp_count < ack_count))
        else $error("more responses than acknowledged requests");

    a_reset_quiet: assert property (@(posedge CLK)
        rst |=> (!ack && !rsp_valid))
        else $error("ack or rsp_valid active during reset");

endmodule

`default_nettype wire

// ==== bench/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;

    import mem_pkg::*;

    localparam int NUM_FILL       = 64;  // one word write per memory word.
    localparam int NUM_DIRECTED   = 20;
    localparam int NUM_BURST      = 32;
    localparam int NUM_RANDOM     = 200;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES =
        40 * (NUM_FILL + NUM_DIRECTED + NUM_BURST + NUM_RANDOM) + RESET_CYCLES;

    logic        CLK;
    logic        rst;
    logic        req;
    cpu_req_t    cpu_req;
    logic        ack;
    logic        rsp_valid;
    mem_rsp_t    rsp;

    logic [7:0]  model [256];
    mem_rsp_t    exp_q [$];
    mem_rsp_t    exp_rsp;
    int          cycles;
    int unsigned seed;

    mem_subsystem #(
        .ADDR_W     (DEFAULT_ADDR_W),
        .FIFO_DEPTH (4)
    ) i_dut (
        .CLK        (CLK),
        .rst        (rst),
        .req        (req),
        .cpu_req    (cpu_req),
        .ack        (ack),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    bind mem_subsystem mem_subsystem_props i_props (
        .CLK       (CLK),
        .rst       (rst),
        .req       (req),
        .ack       (ack),
        .rsp_valid (rsp_valid)
    );

    always #20 CLK = ~CLK;

    // ========================================================================
    // reference model
    // ========================================================================

    function automatic logic [7:0] fill_byte(input logic [7:0] a);
        return {a[2:0], a[7:3]} ^ 8'h5A;
    endfunction

    // applies one access to the byte model; big-endian, lane 0 is addr+0.
    task automatic model_access(input logic wr, input size_t sz, input logic [7:0] addr,
                                input logic [31:0] data, output mem_rsp_t expected);
        int          nbytes;
        logic        misaligned;
        logic [31:0] rd;
        logic [7:0]  a;
        nbytes     = (sz == SIZE_WORD) ? 4 : (sz == SIZE_HALF) ? 2 : 1;
        misaligned = (sz == SIZE_HALF && addr[0]) || (sz == SIZE_WORD && addr[1:0] != 2'b00);
        expected       = '0;
        expected.write = wr;
        rd             = '0;
        if (misaligned) begin
            expected.fault = 1'b1;
        end else begin
            for (int i = 0; i < nbytes; i++) begin
                a = addr + 8'(i);
                if (wr)
                    model[a] = data[8*(nbytes-1-i) +: 8];
                else
                    rd = {rd[23:0], model[a]};
            end
            if (!wr)
                expected.rdata = rd;
        end
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================

    task automatic step();
        @(posedge CLK);
        #2;
    endtask

    // one four-phase exchange.
    task automatic send(input logic wr, input size_t sz, input logic [7:0] addr,
                        input logic [31:0] data);
        mem_rsp_t expected;
        model_access(wr, sz, addr, data, expected);
        exp_q.push_back(expected);
        cpu_req.write = wr;
        cpu_req.size  = sz;
        cpu_req.addr  = addr;
        cpu_req.wdata = data;
        req = 1'b1;
        while (!ack)
            step();
        req = 1'b0;
        while (ack)
            step();
    endtask

    task automatic fill_memory();
        logic [7:0] a;
        for (int w = 0; w < NUM_FILL; w++) begin
            a = 8'(w * 4);
            send(1'b1, SIZE_WORD, a, {fill_byte(a), fill_byte(a + 8'd1),
                                      fill_byte(a + 8'd2), fill_byte(a + 8'd3)});
        end
    endtask

    task automatic random_access();
        logic [31:0] r;
        size_t       sz;
        r = $urandom;
        case (r[2:1])
            2'd0:    sz = SIZE_BYTE;
            2'd1:    sz = SIZE_HALF;
            default: sz = SIZE_WORD;
        endcase
        send(r[0], sz, r[15:8], $urandom);
    endtask

    initial begin
        CLK     = 1'b0;
        rst     = 1'b1;
        req     = 1'b0;
        cpu_req = '0;
        seed    = $urandom(95179);
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        rst = 1'b0;
        fill_memory();

        // word write then read back.
        send(1'b1, SIZE_WORD, 8'h10, 32'hDEAD_BEEF);
        send(1'b0, SIZE_WORD, 8'h10, 32'd0);

        // partial writes composed into words.
        send(1'b1, SIZE_BYTE, 8'h20, 32'h0000_00AA);
        send(1'b1, SIZE_BYTE, 8'h21, 32'hFFFF_FFBB);
        send(1'b1, SIZE_HALF, 8'h22, 32'h1234_CCDD); // upper half dropped.
        send(1'b0, SIZE_WORD, 8'h20, 32'd0);
        send(1'b1, SIZE_BYTE, 8'h27, 32'h0000_0077);
        send(1'b1, SIZE_HALF, 8'h24, 32'h0000_4455);
        send(1'b0, SIZE_WORD, 8'h24, 32'd0);

        // narrow reads.
        send(1'b0, SIZE_BYTE, 8'h20, 32'd0);
        send(1'b0, SIZE_BYTE, 8'h23, 32'd0);
        send(1'b0, SIZE_BYTE, 8'h25, 32'd0);
        send(1'b0, SIZE_HALF, 8'h22, 32'd0);
        send(1'b0, SIZE_HALF, 8'h24, 32'd0);

        // misaligned accesses, then memory checked unchanged.
        send(1'b1, SIZE_HALF, 8'h31, 32'h0000_9999);
        send(1'b1, SIZE_WORD, 8'h32, 32'h1111_2222);
        send(1'b0, SIZE_WORD, 8'h13, 32'd0);
        send(1'b0, SIZE_HALF, 8'h27, 32'd0);
        send(1'b0, SIZE_WORD, 8'h30, 32'd0);
        send(1'b0, SIZE_WORD, 8'h10, 32'd0);

        // burst of word accesses fills the fifo.
        for (int i = 0; i < NUM_BURST / 2; i++)
            send(1'b1, SIZE_WORD, 8'h80 + 8'(4 * i), $urandom);
        for (int i = 0; i < NUM_BURST / 2; i++)
            send(1'b0, SIZE_WORD, 8'h80 + 8'(4 * i), 32'd0);

        for (int i = 0; i < NUM_RANDOM; i++)
            random_access();

        while (exp_q.size() != 0)
            step();
        repeat (8) step(); // catch stray responses.
        $display("Test completed successfully");
        $finish;
    end

    // ========================================================================
    // checking
    // ========================================================================

    always @(negedge CLK) begin
        if (!rst && rsp_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("ERROR: rsp_valid high with no request outstanding");
                $display("Test failed");
                $fatal(1, "unexpected response");
            end
            exp_rsp = exp_q.pop_front();
            assert (rsp.rdata == exp_rsp.rdata) else begin
                $display("ERROR: rsp.rdata expected 0x%08h got 0x%08h",
                         exp_rsp.rdata, rsp.rdata);
                $display("Test failed");
                $fatal(1, "read data mismatch");
            end
            assert (rsp.write == exp_rsp.write) else begin
                $display("ERROR: rsp.write expected 0x%0h got 0x%0h", exp_rsp.write, rsp.write);
                $display("Test failed");
                $fatal(1, "write flag mismatch");
            end
            assert (rsp.fault == exp_rsp.fault) else begin
                $display("ERROR: rsp.fault expected 0x%0h got 0x%0h", exp_rsp.fault, rsp.fault);
                $display("Test failed");
                $fatal(1, "fault flag mismatch");
            end
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Test failed");
            $fatal(1, "timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    initial cycles = 0;

endmodule

`default_nettype wire

// ==== common/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // ========================================================================
    // widths
    // ========================================================================

    localparam int DEFAULT_ADDR_W = 8; // 256 bytes.

    // ========================================================================
    // access size and lane mask
    // ========================================================================

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_t;

    // bit 3 is lane 0 (address+0), bit 0 is lane 3.
    typedef logic [3:0] frame_mask_t;

    // ========================================================================
    // request and response payloads
    // ========================================================================

    // request as issued by the cpu.
    typedef struct packed {
        logic                      write;
        size_t                     size;
        logic [DEFAULT_ADDR_W-1:0] addr;
        logic [31:0]               wdata; // right-justified.
    } cpu_req_t;

    // formatted request carried through the fifo.
    typedef struct packed {
        logic                      write;
        logic                      fault;
        frame_mask_t               mask;
        logic [DEFAULT_ADDR_W-1:0] base;  // low two bits zero.
        logic [31:0]               wdata; // right-justified, truncated to size.
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata; // zero on writes and faults.
        logic        write;
        logic        fault;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== memory_interface/memory_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_interface #(
    parameter int ADDR_W = mem_pkg::DEFAULT_ADDR_W
) (
    input  wire logic              CLK,
    input  wire logic              rst,
    input  wire logic              pop_valid,
    input  wire mem_pkg::mem_req_t pop_data,
    output logic                   pop_ready,
    output logic                   rsp_valid,
    output mem_pkg::mem_rsp_t      rsp
);

    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_XFER,   // one byte per cycle.
        ST_FINISH
    } mi_state_t;

    // ========================================================================
    // storage and latched request
    // ========================================================================

    logic [7:0]        mem [2**ADDR_W];
    mi_state_t         state;
    mem_req_t          req_q;
    frame_mask_t       lanes_left;
    frame_mask_t       lanes_next;
    logic [1:0]        lane;
    logic [ADDR_W-1:0] byte_addr;
    logic [31:0]       wr_shift;
    logic [31:0]       acc;
    logic [31:0]       wr_align;
    logic              accept;

    // first pending lane, scanning from lane 0 (mask bit 3).
    function automatic logic [1:0] first_lane(input frame_mask_t m);
        logic [1:0] idx;
        idx = 2'd3;
        if (m[3])
            idx = 2'd0;
        else if (m[2])
            idx = 2'd1;
        else if (m[1])
            idx = 2'd2;
        return idx;
    endfunction

    assign pop_ready  = (state == ST_IDLE);
    assign accept     = pop_valid && pop_ready;
    assign lane       = first_lane(lanes_left);
    assign lanes_next = lanes_left & ~(4'b1000 >> lane);
    assign byte_addr  = {req_q.base[ADDR_W-1:2], lane};

    // move the first active byte of the right-justified data to bits 31..24.
    always_comb begin
        case (pop_data.mask)
            4'b1111:                   wr_align = pop_data.wdata;
            4'b1100, 4'b0011:          wr_align = pop_data.wdata << 16;
            default:                   wr_align = pop_data.wdata << 24;
        endcase
    end

    // ========================================================================
    // control
    // ========================================================================

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        if (pop_data.fault || pop_data.mask == '0)
                            state <= ST_FINISH; // memory untouched.
                        else
                            state <= ST_XFER;
                    end
                end
                ST_XFER:   if (lanes_next == '0) state <= ST_FINISH;
                ST_FINISH: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // ========================================================================
    // datapath
    // ========================================================================

    always_ff @(posedge CLK) begin
        if (accept) begin
            req_q      <= pop_data;
            lanes_left <= pop_data.mask;
            wr_shift   <= wr_align;
            acc        <= '0;
        end else if (state == ST_XFER) begin
            lanes_left <= lanes_next;
            wr_shift   <= {wr_shift[23:0], 8'd0};
            acc        <= {acc[23:0], mem[byte_addr]}; // earliest lane ends up highest.
        end
    end

    always_ff @(posedge CLK) begin
        if (state == ST_XFER && req_q.write)
            mem[byte_addr] <= wr_shift[31:24];
    end

    // response.
    assign rsp_valid  = (state == ST_FINISH);
    assign rsp.rdata  = (req_q.write || req_q.fault) ? 32'd0 : acc;
    assign rsp.write  = req_q.write;
    assign rsp.fault  = req_q.fault;

endmodule

`default_nettype wire

// ==== project.f ====
common/mem_pkg.sv
src/access_formatter.sv
src/req_fifo.sv
memory_interface/memory_interface.sv
src/mem_subsystem.sv
bench/mem_subsystem_props.sv
bench/mem_subsystem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the mem_subsystem simulation with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mem_subsystem_tb \
    -Mdir obj_dir \
    -f project.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vmem_subsystem_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0

// ==== src/access_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

module access_formatter #(
    parameter int ADDR_W = mem_pkg::DEFAULT_ADDR_W
) (
    input  wire logic              CLK,
    input  wire logic              rst,
    input  wire logic              req,
    input  wire mem_pkg::cpu_req_t cpu_req,
    output logic                   ack,
    output logic                   push_valid,
    output mem_pkg::mem_req_t      push_data,
    input  wire logic              push_ready
);

    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PUSH,
        ST_WAIT  // ack held until req drops.
    } fmt_state_t;

    fmt_state_t state;
    mem_req_t   fmt;
    mem_req_t   req_q;
    logic [1:0] offset;

    assign offset = cpu_req.addr[1:0];

    // ========================================================================
    // mask, base and alignment
    // ========================================================================

    always_comb begin
        fmt       = '0;
        fmt.write = cpu_req.write;
        fmt.base  = {cpu_req.addr[ADDR_W-1:2], 2'b00};
        case (cpu_req.size)
            SIZE_BYTE: begin
                fmt.mask  = 4'b1000 >> offset;
                fmt.wdata = {24'd0, cpu_req.wdata[7:0]};
            end
            SIZE_HALF: begin
                fmt.wdata = {16'd0, cpu_req.wdata[15:0]};
                case (offset)
                    2'd0:    fmt.mask  = 4'b1100;
                    2'd2:    fmt.mask  = 4'b0011;
                    default: fmt.fault = 1'b1; // odd half offset.
                endcase
            end
            SIZE_WORD: begin
                fmt.wdata = cpu_req.wdata;
                if (offset == 2'd0)
                    fmt.mask = 4'b1111;
                else
                    fmt.fault = 1'b1;
            end
            default: fmt.fault = 1'b1; // undefined size code.
        endcase
    end

    // ========================================================================
    // four-phase handshake
    // ========================================================================

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (req) state <= ST_PUSH;
                ST_PUSH: if (push_ready) state <= ST_WAIT;
                ST_WAIT: if (!req) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request is stable while req is high, so one sample is enough.
    always_ff @(posedge CLK) begin
        if (state == ST_IDLE && req)
            req_q <= fmt;
    end

    assign push_valid = (state == ST_PUSH);
    assign push_data  = req_q;
    assign ack        = (state == ST_WAIT); // rises after the push, falls after req.

endmodule

`default_nettype wire

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem #(
    parameter int ADDR_W     = mem_pkg::DEFAULT_ADDR_W,
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic              CLK,
    input  wire logic              rst,
    input  wire logic              req,
    input  wire mem_pkg::cpu_req_t cpu_req,
    output logic                   ack,
    output logic                   rsp_valid,
    output mem_pkg::mem_rsp_t      rsp
);

    import mem_pkg::*;

    // ========================================================================
    // internal links
    // ========================================================================

    logic     push_valid;
    logic     push_ready;
    mem_req_t push_data;
    logic     pop_valid;
    logic     pop_ready;
    mem_req_t pop_data;

    access_formatter #(
        .ADDR_W     (ADDR_W)
    ) i_formatter (
        .CLK        (CLK),
        .rst        (rst),
        .req        (req),
        .cpu_req    (cpu_req),
        .ack        (ack),
        .push_valid (push_valid),
        .push_data  (push_data),
        .push_ready (push_ready)
    );

    req_fifo #(
        .T          (mem_req_t),
        .DEPTH      (FIFO_DEPTH)
    ) i_fifo (
        .CLK        (CLK),
        .rst        (rst),
        .push_valid (push_valid),
        .push_data  (push_data),
        .push_ready (push_ready),
        .pop_valid  (pop_valid),
        .pop_data   (pop_data),
        .pop_ready  (pop_ready)
    );

    memory_interface #(
        .ADDR_W     (ADDR_W)
    ) i_mem_if (
        .CLK        (CLK),
        .rst        (rst),
        .pop_valid  (pop_valid),
        .pop_data   (pop_data),
        .pop_ready  (pop_ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire

// ==== src/req_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  wire logic CLK,
    input  wire logic rst,
    input  wire logic push_valid,
    input  wire T     push_data,
    output logic      push_ready,
    output logic      pop_valid,
    output T          pop_data,
    input  wire logic pop_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T               mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic           do_push;
    logic           do_pop;

    assign pop_valid  = (count != '0);
    assign push_ready = (count != CNT_W'(DEPTH)) || pop_ready; // pass-through when full.
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;
    assign pop_data   = mem[rd_ptr];

    // storage.
    always_ff @(posedge CLK) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire
